// File: Bender.yml
package:
  name: top_system

sources:
  - verilog/board_pkg.sv
  - verilog/mon_pkg.sv
  - verilog/reset_stretch.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/cmd_monitor.sv
  - verilog/mem_ctrl.sv
  - verilog/top_system.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/top_system_chk.sv
      - verification/top_system_tb.sv

// File: all.f
verilog/board_pkg.sv
verilog/mon_pkg.sv
verilog/reset_stretch.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_monitor.sv
verilog/mem_ctrl.sv
verilog/top_system.sv
verification/tb_clock.sv
verification/top_system_chk.sv
verification/top_system_tb.sv

// File: verification/tb_clock.sv
module tb_clock (
   output logic sysclk
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD_NS = 10;

   initial begin
      sysclk = 1'b0;
      forever #(PERIOD_NS / 2) sysclk = ~sysclk;
   end

endmodule

// File: verification/top_system_chk.sv
module top_system_chk (
   input logic           sysclk,
   input logic           sys_reset,
   input logic           mem_req,
   input logic           mem_ack,
   input logic           mem_we,
   input mon_pkg::addr_t mem_addr,
   input mon_pkg::byte_t mem_wdata,
   input logic           tx_req,
   input logic           tx_ack,
   input logic           trap
);

   timeunit 1ns;
   timeprecision 100ps;

   int assert_errors = 0;

   // Requests are held until acked
   mem_req_held: assert property (@(posedge sysclk) disable iff (sys_reset)
      mem_req && !mem_ack |=> mem_req)
      else begin
         assert_errors++;
         $error("mem_req dropped before mem_ack");
      end

   tx_req_held: assert property (@(posedge sysclk) disable iff (sys_reset)
      tx_req && !tx_ack |=> tx_req)
      else begin
         assert_errors++;
         $error("tx_req dropped before tx_ack");
      end

   mem_fields_stable: assert property (@(posedge sysclk) disable iff (sys_reset)
      mem_req && $past(mem_req) |-> $stable({mem_we, mem_addr, mem_wdata}))
      else begin
         assert_errors++;
         $error("memory request fields changed while mem_req was high");
      end

   // Sticky until reset
   trap_sticky: assert property (@(posedge sysclk) disable iff (sys_reset)
      !$fell(trap))
      else begin
         assert_errors++;
         $error("trap fell outside reset");
      end

endmodule

// File: verification/top_system_tb.sv
module top_system_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT_CYCLES   = board_pkg::BIT_CYCLES;
   localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
   localparam int READY_DELAY  = board_pkg::CALIB_CYCLES + board_pkg::RESET_CYCLES;
   localparam int CLK_NS       = 10;
   // Directed, random mix, unknown and post-reset commands with some spare
   localparam int NUM_CMDS     = 72;
   localparam longint RESET_MARGIN_NS = 2 * 4 * READY_DELAY * CLK_NS;
   localparam longint TIMEOUT_NS = longint'(NUM_CMDS) * 4 * FRAME_CYCLES * CLK_NS
                                   + RESET_MARGIN_NS;

   logic sysclk;
   logic reset;
   logic uart_rxd;
   logic uart_txd;
   logic ready;
   logic trap;

   mon_pkg::byte_t mem_model [0:255];
   bit             written [0:255];
   mon_pkg::addr_t written_q [$];
   logic           exp_trap;
   logic [15:0]    lfsr_state;
   int             value_errors;
   int             protocol_errors;

   tb_clock u_clock (.sysclk(sysclk));

   top_system uut (
      .sysclk   (sysclk),
      .reset    (reset),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .ready    (ready),
      .trap     (trap)
   );

   bind cmd_monitor top_system_chk u_chk (
      .sysclk    (sysclk),
      .sys_reset (sys_reset),
      .mem_req   (mem_req),
      .mem_ack   (mem_ack),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .tx_req    (tx_req),
      .tx_ack    (tx_ack),
      .trap      (trap)
   );

   //////////////////////////////////////////////////
   // Random numbers
   //////////////////////////////////////////////////

   function automatic logic [15:0] galois_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [7:0] random_bits(input int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[6:0], lfsr_state[0]};
         lfsr_state = galois_step(lfsr_state);
      end
      return r;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic compare_byte(input string what, input mon_pkg::byte_t got,
                               input mon_pkg::byte_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s got %02h expected %02h", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_delay(input string what, input int got, input int exp,
                              input int slack);
      if (got < exp - slack || got > exp + slack) begin
         $display("[ERROR] %0t ns: %s got %0d cycles expected %0d", $time, what, got, exp);
         value_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // UART host side
   //////////////////////////////////////////////////

   task automatic send_byte(input mon_pkg::byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge sysclk);
         #1 uart_rxd = frame[i];
         repeat (BIT_CYCLES - 1) @(posedge sysclk);
      end
   endtask

   // Samples mid bit on falling clock edges
   task automatic receive_byte(input int limit, output mon_pkg::byte_t data,
                               output bit got);
      int n;
      n = 0;
      got = 1'b0;
      data = '0;
      do begin
         @(negedge sysclk);
         n++;
      end while (uart_txd !== 1'b0 && n < limit);
      if (uart_txd === 1'b0) begin
         repeat (board_pkg::HALF_BIT) @(negedge sysclk);
         if (uart_txd !== 1'b0) begin
            $display("Start bit on uart_txd did not hold to its middle at %0t ns", $time);
            protocol_errors++;
         end
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge sysclk);
            data[i] = uart_txd;
         end
         repeat (BIT_CYCLES) @(negedge sysclk);
         if (uart_txd !== 1'b1) begin
            $display("Stop bit on uart_txd was low at %0t ns", $time);
            protocol_errors++;
         end
         got = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////
   // Commands
   //////////////////////////////////////////////////

   task automatic write_mem(input mon_pkg::addr_t a, input mon_pkg::byte_t d);
      mon_pkg::byte_t reply;
      bit             got;
      fork
         begin
            send_byte(mon_pkg::CMD_WRITE);
            send_byte(a);
            send_byte(d);
         end
         receive_byte(5 * FRAME_CYCLES, reply, got);
      join
      if (!got) begin
         $display("No reply to write of address %02h", a);
         protocol_errors++;
      end else begin
         compare_byte("write reply", reply, mon_pkg::REPLY_OK);
      end
      mem_model[a] = d;
      if (!written[a]) begin
         written[a] = 1'b1;
         written_q.push_back(a);
      end
      @(negedge sysclk);
      check_flag("trap after write", trap, exp_trap);
   endtask

   task automatic read_mem(input mon_pkg::addr_t a);
      mon_pkg::byte_t reply;
      bit             got;
      fork
         begin
            send_byte(mon_pkg::CMD_READ);
            send_byte(a);
         end
         receive_byte(4 * FRAME_CYCLES, reply, got);
      join
      if (!got) begin
         $display("No reply to read of address %02h", a);
         protocol_errors++;
      end else begin
         compare_byte("read data", reply, mem_model[a]);
      end
      @(negedge sysclk);
      check_flag("trap after read", trap, exp_trap);
   endtask

   // One frame to send plus three frame times of silence
   task automatic send_unknown(input mon_pkg::byte_t b);
      mon_pkg::byte_t reply;
      bit             got;
      fork
         send_byte(b);
         receive_byte(4 * FRAME_CYCLES, reply, got);
      join
      if (got) begin
         $display("Unexpected reply %02h to unknown command %02h", reply, b);
         protocol_errors++;
      end
      exp_trap = 1'b1;
      @(negedge sysclk);
      check_flag("trap after unknown command", trap, exp_trap);
   endtask

   task automatic reset_and_wait();
      int cycles;
      @(posedge sysclk);
      #1 reset = 1'b1;
      @(negedge sysclk);
      check_flag("ready in reset", ready, 1'b0);
      check_flag("trap in reset", trap, 1'b0);
      @(posedge sysclk);
      @(posedge sysclk);
      #1 reset = 1'b0;
      for (int i = 0; i < 256; i++)
         written[i] = 1'b0;
      written_q.delete();
      exp_trap = 1'b0;
      cycles = 0;
      // Count rising edges after release, look at each one half a cycle later
      while (ready !== 1'b1 && cycles < 4 * READY_DELAY) begin
         @(posedge sysclk);
         cycles++;
         @(negedge sysclk);
         if (ready !== 1'b1) begin
            check_flag("uart_txd before ready", uart_txd, 1'b1);
            check_flag("trap before ready", trap, 1'b0);
         end
      end
      if (ready !== 1'b1) begin
         $display("ready never rose after reset was released");
         protocol_errors++;
      end else begin
         check_delay("ready delay", cycles, READY_DELAY, 1);
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      mon_pkg::addr_t a;
      mon_pkg::byte_t d;
      int             total;
      reset = 1'b1;
      uart_rxd = 1'b1;
      exp_trap = 1'b0;
      lfsr_state = 16'd83;
      value_errors = 0;
      protocol_errors = 0;

      reset_and_wait();

      // Write, read back, overwrite
      a = random_bits(8);
      d = random_bits(8);
      write_mem(a, d);
      read_mem(a);
      write_mem(a, ~d);
      read_mem(a);

      for (int i = 0; i < 60; i++) begin
         if (written_q.size() == 0 || random_bits(1)) begin
            a = random_bits(8);
            d = random_bits(8);
            write_mem(a, d);
         end else begin
            a = written_q[random_bits(8) % written_q.size()];
            read_mem(a);
         end
      end

      do
         d = random_bits(8);
      while (d == mon_pkg::CMD_WRITE || d == mon_pkg::CMD_READ);
      send_unknown(d);
      a = random_bits(8);
      write_mem(a, random_bits(8));
      read_mem(a);

      // Reset mid-run clears trap and the model
      reset_and_wait();
      a = random_bits(8);
      write_mem(a, random_bits(8));
      read_mem(a);

      repeat (4) @(posedge sysclk);
      total = value_errors + protocol_errors + uut.u_cmd_monitor.u_chk.assert_errors;
      $display("Errors: %0d value, %0d protocol, %0d assertion", value_errors,
               protocol_errors, uut.u_cmd_monitor.u_chk.assert_errors);
      if (total == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: verilog/board_pkg.sv
package board_pkg;

   //////////////////////////////////////////////////
   // Reset and memory bring-up
   //////////////////////////////////////////////////

   // Internal reset held this long after calibration
   localparam int RESET_CYCLES = 16;
   localparam int RESET_W = $clog2(RESET_CYCLES);

   // Memory calibration time after board reset
   localparam int CALIB_CYCLES = 40;
   localparam int CALIB_W = $clog2(CALIB_CYCLES);

   //////////////////////////////////////////////////
   // UART timing
   //////////////////////////////////////////////////

   // sysclk cycles per bit, same for rx and tx
   localparam int BIT_CYCLES = 8;
   localparam int BIT_W = $clog2(BIT_CYCLES);

   // Mid-bit point of the start bit
   localparam int HALF_BIT = BIT_CYCLES / 2;

endpackage

// File: verilog/cmd_monitor.sv
module cmd_monitor (
   input  logic           sysclk,
   input  logic           sys_reset,
   input  mon_pkg::byte_t rx_data,
   input  logic           rx_valid,
   output logic           tx_req,
   output mon_pkg::byte_t tx_data,
   input  logic           tx_ack,
   output logic           mem_req,
   output logic           mem_we,
   output mon_pkg::addr_t mem_addr,
   output mon_pkg::byte_t mem_wdata,
   input  logic           mem_ack,
   input  mon_pkg::byte_t mem_rdata,
   output logic           trap
);

   mon_pkg::mon_state_t state;

   //////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge sysclk or posedge sys_reset) begin
      if (sys_reset) begin
         state   <= mon_pkg::IDLE;
         mem_req <= 1'b0;
         mem_we  <= 1'b0;
         tx_req  <= 1'b0;
         trap    <= 1'b0;
      end else begin
         case (state)
            mon_pkg::IDLE: begin
               if (rx_valid) begin
                  if (rx_data == mon_pkg::CMD_WRITE || rx_data == mon_pkg::CMD_READ) begin
                     mem_we <= (rx_data == mon_pkg::CMD_WRITE);
                     state  <= mon_pkg::GET_ADDR;
                  end else begin
                     // Unknown command, no reply
                     trap <= 1'b1;
                  end
               end
            end
            mon_pkg::GET_ADDR: begin
               if (rx_valid) begin
                  if (mem_we) begin
                     state <= mon_pkg::GET_DATA;
                  end else begin
                     mem_req <= 1'b1;
                     state   <= mon_pkg::MEM_REQ;
                  end
               end
            end
            mon_pkg::GET_DATA: begin
               if (rx_valid) begin
                  mem_req <= 1'b1;
                  state   <= mon_pkg::MEM_REQ;
               end
            end
            mon_pkg::MEM_REQ: begin
               if (mem_ack) begin
                  mem_req <= 1'b0;
                  state   <= mon_pkg::MEM_DONE;
               end
            end
            mon_pkg::MEM_DONE: begin
               if (!mem_ack) begin
                  tx_req <= 1'b1;
                  state  <= mon_pkg::TX_REQ;
               end
            end
            mon_pkg::TX_REQ: begin
               if (tx_ack) begin
                  tx_req <= 1'b0;
                  state  <= mon_pkg::TX_DONE;
               end
            end
            default: begin
               if (!tx_ack)
                  state <= mon_pkg::IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Command and reply bytes
   //////////////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (rx_valid && state == mon_pkg::GET_ADDR)
         mem_addr <= rx_data;
      if (rx_valid && state == mon_pkg::GET_DATA)
         mem_wdata <= rx_data;
      // Read data is only valid with the ack
      if (mem_ack && state == mon_pkg::MEM_REQ)
         tx_data <= mem_we ? mon_pkg::REPLY_OK : mem_rdata;
   end

endmodule

// File: verilog/mem_ctrl.sv
module mem_ctrl (
   input  logic           sysclk,
   input  logic           reset,
   input  logic           mem_req,
   input  logic           mem_we,
   input  mon_pkg::addr_t mem_addr,
   input  mon_pkg::byte_t mem_wdata,
   output logic           mem_ack,
   output mon_pkg::byte_t mem_rdata,
   output logic           calib_done
);

   mon_pkg::byte_t                mem [0:255];
   logic [board_pkg::CALIB_W-1:0] calib_cnt;
   logic                          access;

   // One access per req, held off until calibrated
   assign access = mem_req && !mem_ack && calib_done;

   // Stand-in for the DDR calibration sequence
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         calib_cnt  <= '0;
         calib_done <= 1'b0;
      end else if (!calib_done) begin
         calib_cnt <= calib_cnt + 1'b1;
         if (calib_cnt == board_pkg::CALIB_W'(board_pkg::CALIB_CYCLES - 1))
            calib_done <= 1'b1;
      end
   end

   // Ack up one cycle after req, down one cycle after req drops
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset)
         mem_ack <= 1'b0;
      else if (access)
         mem_ack <= 1'b1;
      else if (!mem_req)
         mem_ack <= 1'b0;
   end

   always_ff @(posedge sysclk) begin
      if (access) begin
         if (mem_we)
            mem[mem_addr] <= mem_wdata;
         mem_rdata <= mem[mem_addr];
      end
   end

endmodule

// File: verilog/mon_pkg.sv
package mon_pkg;

   typedef logic [7:0] byte_t;
   typedef logic [7:0] addr_t;

   // Host command bytes (ASCII)
   localparam byte_t CMD_WRITE = 8'h57;
   localparam byte_t CMD_READ  = 8'h52;

   // Reply to a completed write
   localparam byte_t REPLY_OK  = 8'h4B;

   // Monitor sequencer
   typedef enum logic [2:0] {
      IDLE,
      GET_ADDR,
      GET_DATA,
      MEM_REQ,
      MEM_DONE,
      TX_REQ,
      TX_DONE
   } mon_state_t;

endpackage

// File: verilog/reset_stretch.sv
module reset_stretch (
   input  logic sysclk,
   input  logic reset,
   input  logic calib_done,
   output logic sys_reset,
   output logic ready
);

   logic [board_pkg::RESET_W-1:0] cnt;

   // Count restarts whenever calibration is lost
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         cnt       <= '0;
         sys_reset <= 1'b1;
         ready     <= 1'b0;
      end else if (!calib_done) begin
         cnt       <= '0;
         sys_reset <= 1'b1;
         ready     <= 1'b0;
      end else if (sys_reset) begin
         cnt <= cnt + 1'b1;
         // Last stretch cycle, release on this edge
         if (cnt == board_pkg::RESET_W'(board_pkg::RESET_CYCLES - 1)) begin
            sys_reset <= 1'b0;
            ready     <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/top_system.sv
module top_system (
   input  logic sysclk,
   input  logic reset,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic ready,
   output logic trap
);

   logic            sys_reset;
   logic            calib_done;

   mon_pkg::byte_t  rx_data;
   logic            rx_valid;

   logic            tx_req;
   logic            tx_ack;
   mon_pkg::byte_t  tx_data;

   logic            mem_req;
   logic            mem_we;
   logic            mem_ack;
   mon_pkg::addr_t  mem_addr;
   mon_pkg::byte_t  mem_wdata;
   mon_pkg::byte_t  mem_rdata;

   //////////////////////////////////////////////////
   // Reset held until memory is calibrated
   //////////////////////////////////////////////////

   reset_stretch u_reset_stretch (
      .sysclk     (sysclk),
      .reset      (reset),
      .calib_done (calib_done),
      .sys_reset  (sys_reset),
      .ready      (ready)
   );

   //////////////////////////////////////////////////
   // Serial port
   //////////////////////////////////////////////////

   uart_rx u_uart_rx (
      .sysclk    (sysclk),
      .sys_reset (sys_reset),
      .uart_rxd  (uart_rxd),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

   uart_tx u_uart_tx (
      .sysclk    (sysclk),
      .sys_reset (sys_reset),
      .tx_req    (tx_req),
      .tx_data   (tx_data),
      .tx_ack    (tx_ack),
      .uart_txd  (uart_txd)
   );

   //////////////////////////////////////////////////
   // Command monitor and memory
   //////////////////////////////////////////////////

   cmd_monitor u_cmd_monitor (
      .sysclk    (sysclk),
      .sys_reset (sys_reset),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .tx_req    (tx_req),
      .tx_data   (tx_data),
      .tx_ack    (tx_ack),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .trap      (trap)
   );

   // Runs on the board reset, outside the stretched one
   mem_ctrl u_mem_ctrl (
      .sysclk     (sysclk),
      .reset      (reset),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .calib_done (calib_done)
   );

endmodule

// File: verilog/uart_rx.sv
module uart_rx (
   input  logic           sysclk,
   input  logic           sys_reset,
   input  logic           uart_rxd,
   output mon_pkg::byte_t rx_data,
   output logic           rx_valid
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                   state;
   logic [board_pkg::BIT_W-1:0] cyc;
   logic [2:0]                  bit_cnt;
   logic                        rxd_meta;
   logic                        rxd_sync;
   logic                        rxd_prev;
   logic                        bit_end;

   assign bit_end = (cyc == board_pkg::BIT_W'(board_pkg::BIT_CYCLES - 1));

   always_ff @(posedge sysclk or posedge sys_reset) begin
      if (sys_reset) begin
         state    <= RX_IDLE;
         cyc      <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= uart_rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (rxd_prev && !rxd_sync) begin
                  state <= RX_START;
                  cyc   <= '0;
               end
            end
            RX_START: begin
               // Recheck the line mid start bit, a glitch goes back to idle
               if (cyc == board_pkg::BIT_W'(board_pkg::HALF_BIT - 1)) begin
                  cyc     <= '0;
                  bit_cnt <= '0;
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  cyc <= cyc + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  cyc     <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= RX_STOP;
               end else begin
                  cyc <= cyc + 1'b1;
               end
            end
            default: begin
               // Framing error drops the byte
               if (bit_end) begin
                  cyc      <= '0;
                  state    <= RX_IDLE;
                  rx_valid <= rxd_sync;
               end else begin
                  cyc <= cyc + 1'b1;
               end
            end
         endcase
      end
   end

   // LSB first
   always_ff @(posedge sysclk) begin
      if (state == RX_DATA && bit_end)
         rx_data <= {rxd_sync, rx_data[7:1]};
   end

endmodule

// File: verilog/uart_tx.sv
module uart_tx (
   input  logic           sysclk,
   input  logic           sys_reset,
   input  logic           tx_req,
   input  mon_pkg::byte_t tx_data,
   output logic           tx_ack,
   output logic           uart_txd
);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   tx_state_t                   state;
   logic [board_pkg::BIT_W-1:0] cyc;
   logic [2:0]                  bit_cnt;
   mon_pkg::byte_t              shreg;
   logic                        load;
   logic                        bit_end;
   logic                        shift;

   // New byte only once the frame is out and the last ack has dropped
   assign load    = (state == TX_IDLE) && tx_req && !tx_ack;
   assign bit_end = (cyc == board_pkg::BIT_W'(board_pkg::BIT_CYCLES - 1));
   assign shift   = bit_end && (state == TX_START || state == TX_DATA);

   always_ff @(posedge sysclk or posedge sys_reset) begin
      if (sys_reset) begin
         state    <= TX_IDLE;
         cyc      <= '0;
         bit_cnt  <= '0;
         tx_ack   <= 1'b0;
         uart_txd <= 1'b1;
      end else begin
         if (tx_ack && !tx_req)
            tx_ack <= 1'b0;
         if (load) begin
            // Start bit goes out with the ack
            tx_ack   <= 1'b1;
            uart_txd <= 1'b0;
            cyc      <= '0;
            state    <= TX_START;
         end else if (state != TX_IDLE) begin
            cyc <= bit_end ? '0 : cyc + 1'b1;
         end
         if (shift)
            uart_txd <= shreg[0];
         if (bit_end) begin
            case (state)
               TX_START: begin
                  bit_cnt <= '0;
                  state   <= TX_DATA;
               end
               TX_DATA: begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= TX_STOP;
               end
               TX_STOP: state <= TX_IDLE;
               default: state <= state;
            endcase
         end
      end
   end

   // Fills with ones, so the stop bit falls out after bit 7
   always_ff @(posedge sysclk) begin
      if (load)
         shreg <= tx_data;
      else if (shift)
         shreg <= {1'b1, shreg[7:1]};
   end

endmodule
